//--- acc_disp.f
design/acc_disp_pkg.sv
design/acc_ldst_counter.sv
design/acc_insn_queue.sv
design/acc_spec_tracker.sv
design/acc_mem_tracker.sv
design/acc_req_register.sv
design/acc_disp_top.sv
bench/acc_disp_tb.sv

//--- Makefile
# Verilator build and run for the accelerator dispatcher

VERILATOR ?= verilator
TOP       ?= acc_disp_tb
FLIST     ?= acc_disp.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: build run clean

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

//--- bench/acc_disp_tb.sv
/*
 * Accelerator dispatcher testbench
 * Issues, commits and flushes instructions, checks requests, stalls and halt
 */
`timescale 1ns/1ps
`default_nettype none

module acc_disp_tb;
  import acc_disp_pkg::*;

  localparam int unsigned ClkPeriod   = 8;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned WaitLimit   = 200;
  localparam int unsigned Seed        = 93695;

  // Expected request as seen on the accelerator port
  typedef struct packed {
    logic [31:0] insn;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [2:0]  id;
  } req_model_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        issue_valid_i;
  fu_e         issue_fu_i;
  acc_op_e     issue_op_i;
  trans_id_t   issue_trans_id_i;
  logic [31:0] issue_insn_i;
  xlen_t       issue_rs1_i;
  xlen_t       issue_rs2_i;
  logic        issue_stall_o;
  logic        commit_valid_i;
  trans_id_t   commit_trans_id_i;
  logic        flush_i;
  logic        cons_en_i;
  logic        commit_st_barrier_i;
  logic        halt_o;
  logic        acc_req_valid_o;
  logic        acc_req_ready_i;
  logic [31:0] acc_req_insn_o;
  xlen_t       acc_req_rs1_o;
  xlen_t       acc_req_rs2_o;
  trans_id_t   acc_req_id_o;
  logic        acc_load_complete_i;
  logic        acc_store_complete_i;
  logic        acc_store_pending_i;

  // Model state
  req_model_t  model_q [$];
  logic        committed [8];
  int          n_checks;
  int          n_errors;
  req_model_t  exp_req;
  logic        exp_found;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  acc_disp_top i_acc_disp_top (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .issue_valid_i       (issue_valid_i),
    .issue_fu_i          (issue_fu_i),
    .issue_op_i          (issue_op_i),
    .issue_trans_id_i    (issue_trans_id_i),
    .issue_insn_i        (issue_insn_i),
    .issue_rs1_i         (issue_rs1_i),
    .issue_rs2_i         (issue_rs2_i),
    .issue_stall_o       (issue_stall_o),
    .commit_valid_i      (commit_valid_i),
    .commit_trans_id_i   (commit_trans_id_i),
    .flush_i             (flush_i),
    .cons_en_i           (cons_en_i),
    .commit_st_barrier_i (commit_st_barrier_i),
    .halt_o              (halt_o),
    .acc_req_valid_o     (acc_req_valid_o),
    .acc_req_ready_i     (acc_req_ready_i),
    .acc_req_insn_o      (acc_req_insn_o),
    .acc_req_rs1_o       (acc_req_rs1_o),
    .acc_req_rs2_o       (acc_req_rs2_o),
    .acc_req_id_o        (acc_req_id_o),
    .acc_load_complete_i (acc_load_complete_i),
    .acc_store_complete_i(acc_store_complete_i),
    .acc_store_pending_i (acc_store_pending_i)
  );

  // Oldest issued instruction leaves next, and only once committed
  function automatic logic ref_next_req(output req_model_t r);
    r = '0;
    if (model_q.size() == 0) begin
      return 1'b0;
    end
    r = model_q[0];
    return committed[r.id];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // Compare every transfer mid-cycle, where the outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni && acc_req_valid_o && acc_req_ready_i) begin
      exp_found = ref_next_req(exp_req);
      n_checks++;
      assert (exp_found) else begin
        $display("Request for ID %0d sent with no committed instruction waiting",
                 acc_req_id_o);
        n_errors++;
      end
      if (exp_found) begin
        compare_value("acc_req_insn_o", acc_req_insn_o, exp_req.insn);
        compare_value("acc_req_rs1_o", acc_req_rs1_o, exp_req.rs1);
        compare_value("acc_req_rs2_o", acc_req_rs2_o, exp_req.rs2);
        compare_value("acc_req_id_o", 32'(acc_req_id_o), 32'(exp_req.id));
        committed[exp_req.id] = 1'b0;
        void'(model_q.pop_front());
      end
    end
  end

  task automatic issue_accel(input acc_op_e op, input logic [2:0] id,
                             input logic [31:0] insn, input logic [31:0] rs1,
                             input logic [31:0] rs2);
    int         waited;
    req_model_t ent;
    waited = 0;
    @(posedge clk_i);
    #1;
    issue_valid_i    = 1'b1;
    issue_fu_i       = FU_ACCEL;
    issue_op_i       = op;
    issue_trans_id_i = id;
    issue_insn_i     = insn;
    issue_rs1_i      = rs1;
    issue_rs2_i      = rs2;
    #1;
    while (issue_stall_o && waited < WaitLimit) begin
      @(posedge clk_i);
      #2;
      waited++;
    end
    if (issue_stall_o) begin
      $display("Timeout: issue of ID %0d stayed stalled", id);
      n_errors++;
    end else begin
      ent = '{insn: insn, rs1: rs1, rs2: rs2, id: id};
      model_q.push_back(ent);
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    issue_fu_i    = FU_NONE;
  endtask

  task automatic commit_id(input logic [2:0] id);
    @(posedge clk_i);
    #1;
    commit_valid_i    = 1'b1;
    commit_trans_id_i = id;
    committed[id]     = 1'b1;
    @(posedge clk_i);
    #1;
    commit_valid_i = 1'b0;
  endtask

  // Wait until the model has no request left
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (model_q.size() != 0 && waited < WaitLimit) begin
      @(posedge clk_i);
      waited++;
    end
    #1;
    if (model_q.size() != 0) begin
      $display("Timeout: %0d requests never reached the accelerator", model_q.size());
      n_errors++;
    end
  endtask

  task automatic expect_stall(input fu_e fu, input logic exp, input string label);
    @(posedge clk_i);
    #1;
    issue_fu_i = fu;
    #1;
    compare_value(label, 32'(issue_stall_o), 32'(exp));
    issue_fu_i = FU_NONE;
  endtask

  task automatic pulse_signal(input int which);
    @(posedge clk_i);
    #1;
    case (which)
      0: acc_store_complete_i = 1'b1;
      1: acc_load_complete_i = 1'b1;
      default: commit_st_barrier_i = 1'b1;
    endcase
    @(posedge clk_i);
    #1;
    acc_store_complete_i = 1'b0;
    acc_load_complete_i  = 1'b0;
    commit_st_barrier_i  = 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("%s: %s", name, (n_errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    int         errs;
    int         waited;
    req_model_t held_req;
    void'($urandom(Seed));
    n_checks = 0;
    n_errors = 0;
    for (int i = 0; i < 8; i++) begin
      committed[i] = 1'b0;
    end
    rst_ni = 1'b0;
    issue_valid_i = 1'b0;
    issue_fu_i = FU_NONE;
    issue_op_i = ACC_OP_OTHER;
    issue_trans_id_i = '0;
    issue_insn_i = '0;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    commit_valid_i = 1'b0;
    commit_trans_id_i = '0;
    flush_i = 1'b0;
    cons_en_i = 1'b0;
    commit_st_barrier_i = 1'b0;
    acc_req_ready_i = 1'b1;
    acc_load_complete_i = 1'b0;
    acc_store_complete_i = 1'b0;
    acc_store_pending_i = 1'b0;
    cycles(ResetCycles);
    rst_ni = 1'b1;
    compare_value("acc_req_valid_o", 32'(acc_req_valid_o), 32'd0);
    compare_value("halt_o", 32'(halt_o), 32'd0);

    // Random in-order stream
    errs = n_errors;
    for (int i = 0; i < 12; i++) begin
      issue_accel(ACC_OP_OTHER, 3'(i), $urandom, $urandom, $urandom);
      cycles(2);
      commit_id(3'(i));
    end
    wait_drain();
    end_test("in-order stream", errs);

    // Withheld commit, then flush before commit
    errs = n_errors;
    issue_accel(ACC_OP_OTHER, 3'd4, $urandom, $urandom, $urandom);
    repeat (20) begin
      @(negedge clk_i);
      compare_value("acc_req_valid_o", 32'(acc_req_valid_o), 32'd0);
    end
    commit_id(3'd4);
    wait_drain();
    issue_accel(ACC_OP_OTHER, 3'd5, $urandom, $urandom, $urandom);
    cycles(2);
    flush_i = 1'b1;
    model_q.delete();
    cycles(1);
    flush_i = 1'b0;
    commit_id(3'd5);
    repeat (20) begin
      @(negedge clk_i);
      compare_value("acc_req_valid_o", 32'(acc_req_valid_o), 32'd0);
    end
    committed[5] = 1'b0;
    // Reissued ID still waits for a commit of its own
    issue_accel(ACC_OP_OTHER, 3'd5, $urandom, $urandom, $urandom);
    repeat (5) begin
      @(negedge clk_i);
      compare_value("acc_req_valid_o", 32'(acc_req_valid_o), 32'd0);
    end
    commit_id(3'd5);
    wait_drain();
    end_test("commit and flush", errs);

    // Back-pressure and queue-full stall
    errs = n_errors;
    acc_req_ready_i = 1'b0;
    issue_accel(ACC_OP_OTHER, 3'd0, $urandom, $urandom, $urandom);
    cycles(2);
    commit_id(3'd0);
    held_req = model_q[0];
    issue_accel(ACC_OP_OTHER, 3'd1, $urandom, $urandom, $urandom);
    issue_accel(ACC_OP_OTHER, 3'd2, $urandom, $urandom, $urandom);
    cycles(2);
    commit_id(3'd1);
    commit_id(3'd2);
    expect_stall(FU_ACCEL, 1'b1, "issue_stall_o");
    repeat (10) begin
      @(negedge clk_i);
      compare_value("acc_req_valid_o", 32'(acc_req_valid_o), 32'd1);
      compare_value("acc_req_insn_o", acc_req_insn_o, held_req.insn);
      compare_value("acc_req_rs1_o", acc_req_rs1_o, held_req.rs1);
      compare_value("acc_req_rs2_o", acc_req_rs2_o, held_req.rs2);
      compare_value("acc_req_id_o", 32'(acc_req_id_o), 32'(held_req.id));
    end
    cycles(1);
    acc_req_ready_i = 1'b1;
    wait_drain();
    expect_stall(FU_ACCEL, 1'b0, "issue_stall_o");
    end_test("back-pressure", errs);

    // Consistency stall for stores, then loads, then with the mode off
    errs = n_errors;
    cons_en_i = 1'b1;
    issue_accel(ACC_OP_STORE, 3'd3, $urandom, $urandom, $urandom);
    expect_stall(FU_LOAD, 1'b1, "issue_stall_o");
    expect_stall(FU_STORE, 1'b1, "issue_stall_o");
    commit_id(3'd3);
    wait_drain();
    expect_stall(FU_LOAD, 1'b1, "issue_stall_o");
    pulse_signal(0);
    expect_stall(FU_LOAD, 1'b0, "issue_stall_o");
    expect_stall(FU_STORE, 1'b0, "issue_stall_o");
    issue_accel(ACC_OP_LOAD, 3'd6, $urandom, $urandom, $urandom);
    expect_stall(FU_STORE, 1'b1, "issue_stall_o");
    expect_stall(FU_LOAD, 1'b0, "issue_stall_o");
    commit_id(3'd6);
    wait_drain();
    expect_stall(FU_STORE, 1'b1, "issue_stall_o");
    pulse_signal(1);
    expect_stall(FU_STORE, 1'b0, "issue_stall_o");
    cons_en_i = 1'b0;
    issue_accel(ACC_OP_STORE, 3'd7, $urandom, $urandom, $urandom);
    expect_stall(FU_LOAD, 1'b0, "issue_stall_o");
    expect_stall(FU_STORE, 1'b0, "issue_stall_o");
    commit_id(3'd7);
    wait_drain();
    pulse_signal(0);
    end_test("consistency stall", errs);

    // Store barrier halt
    errs = n_errors;
    acc_store_pending_i = 1'b1;
    pulse_signal(2);
    @(negedge clk_i);
    compare_value("halt_o", 32'(halt_o), 32'd1);
    cycles(1);
    acc_store_pending_i = 1'b0;
    waited = 0;
    while (halt_o && waited < 2) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    compare_value("halt_o", 32'(halt_o), 32'd0);
    pulse_signal(2);
    repeat (5) begin
      @(negedge clk_i);
      compare_value("halt_o", 32'(halt_o), 32'd0);
    end
    end_test("barrier halt", errs);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/acc_disp_top.sv
/*
 * Accelerator dispatcher
 * Queues issued accelerator instructions and sends them out once non-speculative
 */
`timescale 1ns/1ps
`default_nettype none

module acc_disp_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Issue stage
  input  logic                    issue_valid_i,
  input  acc_disp_pkg::fu_e       issue_fu_i,
  input  acc_disp_pkg::acc_op_e   issue_op_i,
  input  acc_disp_pkg::trans_id_t issue_trans_id_i,
  input  logic [31:0]             issue_insn_i,
  input  acc_disp_pkg::xlen_t     issue_rs1_i,
  input  acc_disp_pkg::xlen_t     issue_rs2_i,
  output logic                    issue_stall_o,
  // Commit and control
  input  logic                    commit_valid_i,
  input  acc_disp_pkg::trans_id_t commit_trans_id_i,
  input  logic                    flush_i,
  input  logic                    cons_en_i,
  input  logic                    commit_st_barrier_i,
  output logic                    halt_o,
  // Accelerator
  output logic                    acc_req_valid_o,
  input  logic                    acc_req_ready_i,
  output logic [31:0]             acc_req_insn_o,
  output acc_disp_pkg::xlen_t     acc_req_rs1_o,
  output acc_disp_pkg::xlen_t     acc_req_rs2_o,
  output acc_disp_pkg::trans_id_t acc_req_id_o,
  input  logic                    acc_load_complete_i,
  input  logic                    acc_store_complete_i,
  input  logic                    acc_store_pending_i
);
  import acc_disp_pkg::*;

  logic                 accept;
  logic                 queue_stall;
  logic                 mem_stall;
  acc_insn_t            issue_insn;
  logic                 push_q;
  acc_insn_t            push_insn_q;
  acc_insn_t            head;
  logic                 queue_empty;
  logic                 queue_pop;
  logic [QueueIdxW-1:0] queue_usage;
  logic                 head_ready;
  logic                 req_valid;
  logic                 req_ready;
  acc_req_t             req;
  acc_req_t             req_out;

  // Keep one slot free for the instruction still in the push register
  assign queue_stall   = (queue_usage >= QueueIdxW'(QueueDepth - 1));
  assign issue_stall_o = ((issue_fu_i == FU_ACCEL) && queue_stall) || mem_stall;

  // Accepted accelerator instruction, younger ones die on a flush
  assign accept = issue_valid_i && (issue_fu_i == FU_ACCEL) && !queue_stall && !flush_i;

  assign issue_insn = '{
    insn:     issue_insn_i,
    rs1:      issue_rs1_i,
    rs2:      issue_rs2_i,
    op:       issue_op_i,
    trans_id: issue_trans_id_i
  };

  // Push register in front of the queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= 1'b0;
    end else begin
      push_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      push_insn_q <= issue_insn;
    end
  end

  acc_insn_queue #(
    .dtype(acc_insn_t)
  ) i_acc_insn_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .push_i (push_q),
    .data_i (push_insn_q),
    .pop_i  (queue_pop),
    .data_o (head),
    .empty_o(queue_empty),
    .usage_o(queue_usage)
  );

  // Readiness of the head ID, includes the commit bypass and the flush kill
  acc_spec_tracker i_acc_spec_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .recv_i        (push_q),
    .recv_id_i     (push_insn_q.trans_id),
    .commit_valid_i(commit_valid_i),
    .commit_id_i   (commit_trans_id_i),
    .dispatch_i    (queue_pop),
    .dispatch_id_i (head.trans_id),
    .query_id_i    (head.trans_id),
    .query_ready_o (head_ready)
  );

  // Head leaves once non-speculative and the register takes it
  assign req_valid = !queue_empty && head_ready;
  assign queue_pop = req_valid && req_ready;

  assign req = '{
    insn:     head.insn,
    rs1:      head.rs1,
    rs2:      head.rs2,
    trans_id: head.trans_id
  };

  acc_req_register #(
    .dtype(acc_req_t)
  ) i_acc_req_register (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(req_valid),
    .data_i (req),
    .ready_i(acc_req_ready_i),
    .ready_o(req_ready),
    .valid_o(acc_req_valid_o),
    .data_o (req_out)
  );

  assign acc_req_insn_o = req_out.insn;
  assign acc_req_rs1_o  = req_out.rs1;
  assign acc_req_rs2_o  = req_out.rs2;
  assign acc_req_id_o   = req_out.trans_id;

  // Loads/stores counted at issue and at dispatch into the register
  acc_mem_tracker i_acc_mem_tracker (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .cons_en_i          (cons_en_i),
    .issue_fu_i         (issue_fu_i),
    .issued_i           (accept),
    .issued_op_i        (issue_op_i),
    .dispatched_i       (queue_pop),
    .dispatched_op_i    (head.op),
    .load_complete_i    (acc_load_complete_i),
    .store_complete_i   (acc_store_complete_i),
    .commit_st_barrier_i(commit_st_barrier_i),
    .store_pending_i    (acc_store_pending_i),
    .mem_stall_o        (mem_stall),
    .halt_o             (halt_o)
  );

endmodule

`default_nettype wire

//--- design/acc_req_register.sv
/*
 * Request register
 * One-entry fall-through buffer, holds the payload under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module acc_req_register #(
  parameter type dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  input  dtype data_i,
  input  logic ready_i,
  output logic ready_o,
  output logic valid_o,
  output dtype data_o
);

  logic full_q;
  dtype data_q;

  // Empty register passes the input straight on
  assign ready_o = !full_q;
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Drain on the downstream handshake
      if (ready_i) begin
        full_q <= 1'b0;
      end
    end else if (valid_i && !ready_i) begin
      full_q <= 1'b1;
    end
  end

  // Capture when the fall-through transfer stalls
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/acc_mem_tracker.sv
/*
 * Accelerator memory tracker
 * Counts pending accelerator loads/stores, stalls scalar memory ops, halts on barriers
 */
`timescale 1ns/1ps
`default_nettype none

module acc_mem_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  cons_en_i,
  input  acc_disp_pkg::fu_e     issue_fu_i,
  input  logic                  issued_i,
  input  acc_disp_pkg::acc_op_e issued_op_i,
  input  logic                  dispatched_i,
  input  acc_disp_pkg::acc_op_e dispatched_op_i,
  input  logic                  load_complete_i,
  input  logic                  store_complete_i,
  input  logic                  commit_st_barrier_i,
  input  logic                  store_pending_i,
  output logic                  mem_stall_o,
  output logic                  halt_o
);
  import acc_disp_pkg::*;

  logic ld_issued, st_issued;
  logic ld_disp, st_disp;
  logic spec_ld_zero, disp_ld_zero;
  logic spec_st_zero, disp_st_zero;
  logic no_ld_pending, no_st_pending;
  logic wait_store_q;

  assign ld_issued = issued_i && (issued_op_i == ACC_OP_LOAD);
  assign st_issued = issued_i && (issued_op_i == ACC_OP_STORE);
  assign ld_disp   = dispatched_i && (dispatched_op_i == ACC_OP_LOAD);
  assign st_disp   = dispatched_i && (dispatched_op_i == ACC_OP_STORE);

  // Speculative loads, still flushable
  acc_ldst_counter i_spec_loads (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(flush_i),
    .up_i   (ld_issued),
    .down_i (ld_disp),
    .zero_o (spec_ld_zero)
  );

  // Dispatched loads, wait for completion
  acc_ldst_counter i_disp_loads (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(1'b0),
    .up_i   (ld_disp),
    .down_i (load_complete_i),
    .zero_o (disp_ld_zero)
  );

  // Speculative stores
  acc_ldst_counter i_spec_stores (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(flush_i),
    .up_i   (st_issued),
    .down_i (st_disp),
    .zero_o (spec_st_zero)
  );

  // Dispatched stores
  acc_ldst_counter i_disp_stores (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(1'b0),
    .up_i   (st_disp),
    .down_i (store_complete_i),
    .zero_o (disp_st_zero)
  );

  assign no_ld_pending = spec_ld_zero && disp_ld_zero;
  assign no_st_pending = spec_st_zero && disp_st_zero;

  // Scalar loads wait for stores, scalar stores wait for both
  always_comb begin
    unique case (issue_fu_i)
      FU_LOAD:  mem_stall_o = cons_en_i && !no_st_pending;
      FU_STORE: mem_stall_o = cons_en_i && (!no_st_pending || !no_ld_pending);
      default:  mem_stall_o = 1'b0;
    endcase
  end

  // Barrier sets the halt, it drops once no store is pending
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_store_q <= 1'b0;
    end else begin
      wait_store_q <= (wait_store_q || commit_st_barrier_i) && store_pending_i;
    end
  end

  assign halt_o = wait_store_q;

endmodule

`default_nettype wire

//--- design/acc_spec_tracker.sv
/*
 * Speculation tracker
 * Per trans-ID FSM marking when an accelerator instruction is no longer speculative
 */
`timescale 1ns/1ps
`default_nettype none

module acc_spec_tracker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    recv_i,
  input  acc_disp_pkg::trans_id_t recv_id_i,
  input  logic                    commit_valid_i,
  input  acc_disp_pkg::trans_id_t commit_id_i,
  input  logic                    dispatch_i,
  input  acc_disp_pkg::trans_id_t dispatch_id_i,
  input  acc_disp_pkg::trans_id_t query_id_i,
  output logic                    query_ready_o
);
  import acc_disp_pkg::*;

  typedef enum logic [1:0] {
    SpecIdle    = 2'd0,
    SpecPending = 2'd1,
    SpecReady   = 2'd2
  } spec_state_e;

  spec_state_e state_q [NrSbEntries];
  spec_state_e state_d [NrSbEntries];
  logic        commit_hit;

  always_comb begin
    for (int unsigned i = 0; i < NrSbEntries; i++) begin
      state_d[i] = state_q[i];
      unique case (state_q[i])
        SpecPending: begin
          // Commit wins over a flush in the same cycle
          if (commit_valid_i && (commit_id_i == trans_id_t'(i))) begin
            // Dispatched through the bypass right away
            if (dispatch_i && (dispatch_id_i == trans_id_t'(i))) begin
              state_d[i] = SpecIdle;
            end else begin
              state_d[i] = SpecReady;
            end
          end else if (flush_i) begin
            state_d[i] = SpecIdle;
          end
        end
        SpecReady: begin
          if (dispatch_i && (dispatch_id_i == trans_id_t'(i))) begin
            state_d[i] = SpecIdle;
          end
        end
        default: state_d[i] = state_q[i];
      endcase
      // New arrival, unless it is killed by the flush
      if (recv_i && !flush_i && (recv_id_i == trans_id_t'(i))) begin
        state_d[i] = SpecPending;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NrSbEntries; i++) begin
        state_q[i] <= SpecIdle;
      end
    end else begin
      state_q <= state_d;
    end
  end

  // Same-cycle commit of the queried ID also counts as ready
  assign commit_hit    = commit_valid_i && (commit_id_i == query_id_i) &&
                         (state_q[query_id_i] == SpecPending);
  assign query_ready_o = !flush_i && ((state_q[query_id_i] == SpecReady) || commit_hit);

endmodule

`default_nettype wire

//--- design/acc_insn_queue.sv
/*
 * Accelerator instruction queue
 * Fall-through circular FIFO of QueueDepth entries, flushable
 */
`timescale 1ns/1ps
`default_nettype none

module acc_insn_queue #(
  parameter type dtype = acc_disp_pkg::acc_insn_t
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              push_i,
  input  dtype                              data_i,
  input  logic                              pop_i,
  output dtype                              data_o,
  output logic                              empty_o,
  output logic [acc_disp_pkg::QueueIdxW-1:0] usage_o
);
  import acc_disp_pkg::*;

  dtype                 mem_q [QueueDepth];
  logic [QueueIdxW-1:0] rd_ptr_q, wr_ptr_q;
  logic [QueueIdxW:0]   cnt_q, cnt_d;
  logic                 full;
  logic                 bypass;
  logic                 do_push;
  logic                 do_pop;

  // Pointer increment, wraps at a depth that need not be a power of two
  function automatic logic [QueueIdxW-1:0] next_ptr(input logic [QueueIdxW-1:0] ptr);
    if (ptr == QueueIdxW'(QueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (cnt_q == (QueueIdxW + 1)'(QueueDepth));

  // Empty queue shows the incoming entry at its head
  assign data_o  = (cnt_q == '0) ? data_i : mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0) && !push_i;
  assign usage_o = cnt_q[QueueIdxW-1:0];

  // Push and pop of the same entry on an empty queue leave no trace
  assign bypass  = push_i && pop_i && (cnt_q == '0);
  assign do_push = push_i && !full && !bypass;
  assign do_pop  = pop_i && (cnt_q != '0);

  always_comb begin
    cnt_d = cnt_q;
    if (do_push && !do_pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (do_pop && !do_push) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Drop every queued entry
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      cnt_q <= cnt_d;
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/acc_ldst_counter.sv
/*
 * Load/store pending counter
 * Up/down count with synchronous clear, reports when nothing is pending
 */
`timescale 1ns/1ps
`default_nettype none

module acc_ldst_counter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic up_i,
  input  logic down_i,
  output logic zero_o
);
  import acc_disp_pkg::*;

  logic [CntWidth-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (up_i && !down_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (down_i && !up_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
    // Both or neither hold the count
  end

  assign zero_o = (cnt_q == '0);

endmodule

`default_nettype wire

//--- design/acc_disp_pkg.sv
/*
 * Accelerator dispatcher package
 * Sizes, operation and unit encodings, and payload structs
 */
`default_nettype none

package acc_disp_pkg;

  // Datapath and scoreboard sizes
  localparam int unsigned XLen        = 32;
  localparam int unsigned TransIdBits = 3;
  localparam int unsigned NrSbEntries = 2 ** TransIdBits;

  // Instruction queue depth and its index width
  localparam int unsigned QueueDepth = 3;
  localparam int unsigned QueueIdxW  = $clog2(QueueDepth);

  // Width of each load/store pending counter
  localparam int unsigned CntWidth = 3;

  typedef logic [TransIdBits-1:0] trans_id_t;
  typedef logic [XLen-1:0]        xlen_t;

  // Memory class of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_OTHER = 2'd0,
    ACC_OP_LOAD  = 2'd1,
    ACC_OP_STORE = 2'd2
  } acc_op_e;

  // Unit targeted by the instruction at issue
  typedef enum logic [1:0] {
    FU_NONE  = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2,
    FU_ACCEL = 2'd3
  } fu_e;

  // Queue entry, keeps the op class for load/store tracking
  typedef struct packed {
    logic [31:0] insn;
    xlen_t       rs1;
    xlen_t       rs2;
    acc_op_e     op;
    trans_id_t   trans_id;
  } acc_insn_t;

  // Payload sent to the accelerator
  typedef struct packed {
    logic [31:0] insn;
    xlen_t       rs1;
    xlen_t       rs2;
    trans_id_t   trans_id;
  } acc_req_t;

endpackage

`default_nettype wire
